/* logic/ch_est_pkg.sv */
`default_nettype none

package ch_est_pkg;

    // ========================================
    // output mux select sequences
    // ========================================

    // bits per select step
    localparam int sel_w = 2;
    // six steps per word
    localparam int seq_len = 12;

    // shift-0 pattern, index 0 feeds s_h1, index 1 feeds s_h2
    // lowest group is played first
    localparam logic [1:0][seq_len-1:0] seq_words = {
        12'b10_11_00_00_01_00,
        12'b01_11_10_11_01_00
    };

    // demapper pilot columns, one per burst of a slot
    localparam logic [3:0][3:0] col_table = {4'd13, 4'd12, 4'd6, 4'd5};

    // ========================================
    // FSM state types
    // ========================================

    // multiply burst, store on first slot, accumulate on second
    typedef enum logic [1:0] {
        idle       = 2'b00,
        mult_store = 2'b01,
        mult_add   = 2'b11
    } mult_state_e;

    // adder 1 for shift 0
    typedef enum logic [3:0] {
        a1_idle    = 4'b0000,
        a1_e2      = 4'b0010,
        a1_2e2     = 4'b0011,
        a1_e2_2e3  = 4'b0001,
        a1_e2_2e4  = 4'b0100,
        a1_2e2_5e4 = 4'b0101
    } a1_state_e;

    // adder 2 for shift 0
    typedef enum logic [3:0] {
        a2_idle   = 4'b0000,
        a2_2e1_e3 = 4'b0001,
        a2_e1_2e3 = 4'b0011,
        a2_2e2_e3 = 4'b0010,
        a2_2e2_e4 = 4'b0100,
        a2_5e4    = 4'b0101,
        a2_4e4_e2 = 4'b0111
    } a2_state_e;

    // ========================================
    // bundles between blocks
    // ========================================

    // burst position, seen by the address generator
    typedef struct packed {
        logic       active;
        logic [1:0] cnt;
    } burst_t;

    // input mux selects of one adder
    typedef struct packed {
        logic [2:0] sel_a;
        logic [2:0] sel_b;
    } adder_sel_t;

    // intermediate estimate register enables
    typedef struct packed {
        logic en_e;
        logic en_2e;
        logic en_5e;
    } reg_en_t;

endpackage

`default_nettype wire

/* logic/slot_mult_sched.sv */
`timescale 1ns/100ps
`default_nettype none

module slot_mult_sched (
    input  wire                clk,
    input  wire                rst,
    input  wire                demap_ready,
    input  wire                nrs_gen_ready,
    output ch_est_pkg::burst_t burst,
    output logic               demap_read,
    output logic               est_ack_nrs,
    output logic [1:0]         addr_mem,
    output logic               mult_mem_en,
    output logic               avg_mem_en,
    output logic               e3_ready,
    output logic               est_ack_demap
);

    ch_est_pkg::mult_state_e cs;
    ch_est_pkg::mult_state_e ns;
    logic [1:0]              cnt;
    logic                    first_slot;
    logic                    active;

    // ========================================
    // burst FSM
    // ========================================

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cs <= ch_est_pkg::idle;
        end else begin
            cs <= ns;
        end
    end

    always_comb begin
        case (cs)
            ch_est_pkg::idle: begin
                // ready only looked at here, no back-pressure
                if (demap_ready && nrs_gen_ready) begin
                    ns = first_slot ? ch_est_pkg::mult_store : ch_est_pkg::mult_add;
                end else begin
                    ns = ch_est_pkg::idle;
                end
            end
            ch_est_pkg::mult_store,
            ch_est_pkg::mult_add: begin
                // two cycles per burst, ends on odd count
                ns = cnt[0] ? ch_est_pkg::idle : cs;
            end
            default: ns = ch_est_pkg::idle;
        endcase
    end

    assign active = (cs == ch_est_pkg::mult_store) || (cs == ch_est_pkg::mult_add);

    // ========================================
    // burst counter and slot toggle
    // ========================================

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cnt        <= 2'd0;
            first_slot <= 1'b1;
        end else if (active) begin
            // free-running wrap, four active cycles per slot half
            cnt <= cnt + 2'd1;
            // flip after the second burst
            if (cnt == 2'd3) begin
                first_slot <= ~first_slot;
            end
        end
    end

    // memory write enables, one cycle behind the multiply
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            mult_mem_en <= 1'b0;
            avg_mem_en  <= 1'b0;
        end else begin
            mult_mem_en <= (cs == ch_est_pkg::mult_store);
            avg_mem_en  <= (cs == ch_est_pkg::mult_add);
        end
    end

    assign burst.active  = active;
    assign burst.cnt     = cnt;
    assign demap_read    = active;
    assign est_ack_nrs   = active;
    assign addr_mem      = cnt;
    // third estimate lands on the first cycle of the last add burst
    assign e3_ready      = (cs == ch_est_pkg::mult_add) && (cnt == 2'd2);
    assign est_ack_demap = e3_ready;

    // burst boundaries stay aligned to counter pairs
    a_burst_even_start : assert property (
        @(posedge clk) disable iff (!rst)
        $rose(active) |-> !cnt[0]
    );

endmodule

`default_nettype wire

/* logic/pilot_addr_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module pilot_addr_gen #(
    parameter int nrs_addr_w = 4
) (
    input  wire                    clk,
    input  wire                    rst,
    input  wire ch_est_pkg::burst_t burst,
    output logic [3:0]             col,
    output logic [1:0]             nrs_index_addr,
    output logic [nrs_addr_w-1:0]  rd_addr_nrs
);

    logic [1:0] col_idx;

    // ========================================
    // demapper column
    // ========================================

    // next column after the second cycle of a burst
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            col_idx <= 2'd0;
        end else if (burst.active && burst.cnt[0]) begin
            col_idx <= col_idx + 2'd1;
        end
    end

    assign col = ch_est_pkg::col_table[col_idx];

    // ========================================
    // pilot memory addresses
    // ========================================

    // index to the pilot index gen, read address two words per pilot
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            nrs_index_addr <= 2'd0;
            rd_addr_nrs    <= '0;
        end else if (burst.active) begin
            nrs_index_addr <= nrs_index_addr + 2'd1;
            rd_addr_nrs    <= rd_addr_nrs + nrs_addr_w'(2);
        end
    end

endmodule

`default_nettype wire

/* logic/interp_sched.sv */
`timescale 1ns/100ps
`default_nettype none

module interp_sched (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    e3_ready,
    output ch_est_pkg::adder_sel_t sel_a1,
    output ch_est_pkg::adder_sel_t sel_a2,
    output ch_est_pkg::reg_en_t    reg_en,
    output logic                   valid_eqlz,
    output logic                   load_sel
);

    ch_est_pkg::a1_state_e cs_a1;
    ch_est_pkg::a1_state_e ns_a1;
    ch_est_pkg::a2_state_e cs_a2;
    ch_est_pkg::a2_state_e ns_a2;
    logic                  go_1;

    // ========================================
    // adder state registers
    // ========================================

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cs_a1 <= ch_est_pkg::a1_idle;
            cs_a2 <= ch_est_pkg::a2_idle;
        end else begin
            cs_a1 <= ns_a1;
            cs_a2 <= ns_a2;
        end
    end

    // adder 1, holds a1_e2_2e3 until go_1
    always_comb begin
        case (cs_a1)
            ch_est_pkg::a1_idle:
                ns_a1 = e3_ready ? ch_est_pkg::a1_e2 : ch_est_pkg::a1_idle;
            ch_est_pkg::a1_e2:      ns_a1 = ch_est_pkg::a1_2e2;
            ch_est_pkg::a1_2e2:     ns_a1 = ch_est_pkg::a1_e2_2e3;
            ch_est_pkg::a1_e2_2e3:
                ns_a1 = go_1 ? ch_est_pkg::a1_e2_2e4 : ch_est_pkg::a1_e2_2e3;
            ch_est_pkg::a1_e2_2e4:  ns_a1 = ch_est_pkg::a1_2e2_5e4;
            ch_est_pkg::a1_2e2_5e4: ns_a1 = ch_est_pkg::a1_idle;
            default:                ns_a1 = ch_est_pkg::a1_idle;
        endcase
    end

    // adder 2, straight six-step run
    always_comb begin
        case (cs_a2)
            ch_est_pkg::a2_idle:
                ns_a2 = e3_ready ? ch_est_pkg::a2_2e1_e3 : ch_est_pkg::a2_idle;
            ch_est_pkg::a2_2e1_e3: ns_a2 = ch_est_pkg::a2_e1_2e3;
            ch_est_pkg::a2_e1_2e3: ns_a2 = ch_est_pkg::a2_2e2_e3;
            ch_est_pkg::a2_2e2_e3: ns_a2 = ch_est_pkg::a2_2e2_e4;
            ch_est_pkg::a2_2e2_e4: ns_a2 = ch_est_pkg::a2_5e4;
            ch_est_pkg::a2_5e4:    ns_a2 = ch_est_pkg::a2_4e4_e2;
            ch_est_pkg::a2_4e4_e2: ns_a2 = ch_est_pkg::a2_idle;
            default:               ns_a2 = ch_est_pkg::a2_idle;
        endcase
    end

    // one-cycle pulse, delays adder 1 so 2e3 is in its register
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            go_1 <= 1'b0;
        end else if (go_1) begin
            go_1 <= 1'b0;
        end else if (cs_a1 == ch_est_pkg::a1_e2_2e3) begin
            go_1 <= 1'b1;
        end
    end

    // ========================================
    // mux selects and register enables
    // ========================================

    always_comb begin
        case (cs_a1)
            ch_est_pkg::a1_e2:      sel_a1 = '{sel_a: 3'b000, sel_b: 3'b000};
            ch_est_pkg::a1_2e2:     sel_a1 = '{sel_a: 3'b001, sel_b: 3'b000};
            ch_est_pkg::a1_e2_2e3:  sel_a1 = '{sel_a: 3'b011, sel_b: 3'b001};
            ch_est_pkg::a1_e2_2e4:  sel_a1 = '{sel_a: 3'b011, sel_b: 3'b011};
            ch_est_pkg::a1_2e2_5e4: sel_a1 = '{sel_a: 3'b010, sel_b: 3'b010};
            // idle parks both muxes
            default:                sel_a1 = '{sel_a: 3'b111, sel_b: 3'b111};
        endcase
    end

    always_comb begin
        case (cs_a2)
            ch_est_pkg::a2_2e1_e3: sel_a2 = '{sel_a: 3'b000, sel_b: 3'b000};
            ch_est_pkg::a2_e1_2e3: sel_a2 = '{sel_a: 3'b001, sel_b: 3'b001};
            ch_est_pkg::a2_2e2_e3: sel_a2 = '{sel_a: 3'b011, sel_b: 3'b000};
            ch_est_pkg::a2_2e2_e4: sel_a2 = '{sel_a: 3'b011, sel_b: 3'b011};
            ch_est_pkg::a2_5e4:    sel_a2 = '{sel_a: 3'b010, sel_b: 3'b011};
            ch_est_pkg::a2_4e4_e2: sel_a2 = '{sel_a: 3'b010, sel_b: 3'b010};
            default:               sel_a2 = '{sel_a: 3'b111, sel_b: 3'b111};
        endcase
    end

    // enable in the state after the sum is formed
    assign reg_en.en_e  = (cs_a1 == ch_est_pkg::a1_2e2);
    assign reg_en.en_2e = (cs_a2 == ch_est_pkg::a2_2e2_e3);
    assign reg_en.en_5e = (cs_a2 == ch_est_pkg::a2_4e4_e2);

    // sequencers load one cycle ahead of their first step
    assign load_sel = (cs_a1 == ch_est_pkg::a1_e2);

    // ========================================
    // equaliser valid window
    // ========================================

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_eqlz <= 1'b0;
        end else if (cs_a2 == ch_est_pkg::a2_4e4_e2) begin
            valid_eqlz <= 1'b0;
        end else if (e3_ready) begin
            valid_eqlz <= 1'b1;
        end
    end

    // one interpolation in flight, slot spacing from the multiply side
    a_e3_while_busy : assert property (
        @(posedge clk) disable iff (!rst)
        e3_ready |-> (cs_a2 == ch_est_pkg::a2_idle)
    );

endmodule

`default_nettype wire

/* logic/out_sel_seq.sv */
`timescale 1ns/100ps
`default_nettype none

module out_sel_seq #(
    parameter int word_idx = 0
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          load_sel,
    output logic [ch_est_pkg::sel_w-1:0] s_h
);

    logic [ch_est_pkg::seq_len-1:0] seq;

    // ========================================
    // select word shift register
    // ========================================

    // zeros shift in, so the mux falls back to 00 when done
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            seq <= '0;
        end else if (load_sel) begin
            seq <= ch_est_pkg::seq_words[word_idx];
        end else begin
            seq <= seq >> ch_est_pkg::sel_w;
        end
    end

    // current step
    assign s_h = seq[ch_est_pkg::sel_w-1:0];

endmodule

`default_nettype wire

/* logic/ch_est_ctrl_top.sv */
`timescale 1ns/100ps
`default_nettype none

module ch_est_ctrl_top #(
    parameter int nrs_addr_w = 4
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          demap_ready,
    input  wire                          nrs_gen_ready,
    output logic [3:0]                   col,
    output logic [1:0]                   nrs_index_addr,
    output logic [nrs_addr_w-1:0]        rd_addr_nrs,
    output logic                         demap_read,
    output logic                         est_ack_nrs,
    output logic                         est_ack_demap,
    output logic [1:0]                   addr_mem,
    output logic                         mult_mem_en,
    output logic                         avg_mem_en,
    output logic                         valid_eqlz,
    output ch_est_pkg::adder_sel_t       sel_a1,
    output ch_est_pkg::adder_sel_t       sel_a2,
    output ch_est_pkg::reg_en_t          reg_en,
    output logic [ch_est_pkg::sel_w-1:0] s_h1,
    output logic [ch_est_pkg::sel_w-1:0] s_h2
);

    ch_est_pkg::burst_t                   burst;
    logic                                 e3_ready;
    logic                                 load_sel;
    logic [1:0][ch_est_pkg::sel_w-1:0]    s_h;

    // ========================================
    // multiply side
    // ========================================

    slot_mult_sched u_mult (
        .clk           (clk),
        .rst           (rst),
        .demap_ready   (demap_ready),
        .nrs_gen_ready (nrs_gen_ready),
        .burst         (burst),
        .demap_read    (demap_read),
        .est_ack_nrs   (est_ack_nrs),
        .addr_mem      (addr_mem),
        .mult_mem_en   (mult_mem_en),
        .avg_mem_en    (avg_mem_en),
        .e3_ready      (e3_ready),
        .est_ack_demap (est_ack_demap)
    );

    pilot_addr_gen #(
        .nrs_addr_w (nrs_addr_w)
    ) u_addr (
        .clk            (clk),
        .rst            (rst),
        .burst          (burst),
        .col            (col),
        .nrs_index_addr (nrs_index_addr),
        .rd_addr_nrs    (rd_addr_nrs)
    );

    // ========================================
    // interpolation side
    // ========================================

    interp_sched u_interp (
        .clk        (clk),
        .rst        (rst),
        .e3_ready   (e3_ready),
        .sel_a1     (sel_a1),
        .sel_a2     (sel_a2),
        .reg_en     (reg_en),
        .valid_eqlz (valid_eqlz),
        .load_sel   (load_sel)
    );

    // one sequencer per output mux
    for (genvar i = 0; i < 2; i++) begin : g_seq
        out_sel_seq #(
            .word_idx (i)
        ) u_seq (
            .clk      (clk),
            .rst      (rst),
            .load_sel (load_sel),
            .s_h      (s_h[i])
        );
    end

    assign s_h1 = s_h[0];
    assign s_h2 = s_h[1];

endmodule

`default_nettype wire

/* bench/ch_est_ctrl_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module ch_est_ctrl_tb;

    localparam int addr_w = 4;
    localparam int n_rows = 12;
    localparam int wait_limit = 20;
    // shift-0 select words played lowest group first
    localparam logic [11:0] word_h1 = 12'b01_11_10_11_01_00;
    localparam logic [11:0] word_h2 = 12'b10_11_00_00_01_00;

    logic                   clk;
    logic                   rst;
    logic                   demap_ready;
    logic                   nrs_gen_ready;
    logic [3:0]             col;
    logic [1:0]             nrs_index_addr;
    logic [addr_w-1:0]      rd_addr_nrs;
    logic                   demap_read;
    logic                   est_ack_nrs;
    logic                   est_ack_demap;
    logic [1:0]             addr_mem;
    logic                   mult_mem_en;
    logic                   avg_mem_en;
    logic                   valid_eqlz;
    ch_est_pkg::adder_sel_t sel_a1;
    ch_est_pkg::adder_sel_t sel_a2;
    ch_est_pkg::reg_en_t    reg_en;
    logic [1:0]             s_h1;
    logic [1:0]             s_h2;

    // ========================================
    // stimulus and expected tables
    // ========================================

    // idle cycles before ready (0 picks a random count)
    // then burst kind (1 is add) and expected column
    int         idle_tab [n_rows] = '{2, 0, 1, 0, 3, 0, 0, 4, 1, 0, 2, 0};
    logic       kind_tab [n_rows] = '{1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0,
                                      1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1};
    logic [3:0] col_tab  [n_rows] = '{4'd5, 4'd6, 4'd12, 4'd13, 4'd5, 4'd6,
                                      4'd12, 4'd13, 4'd5, 4'd6, 4'd12, 4'd13};

    // indexed by cycles after e3 with 0 as the idle state
    // adder selects as sel_a, sel_b in octal
    logic [5:0] a1_tab [8] = '{6'o77, 6'o00, 6'o10, 6'o31, 6'o31, 6'o33, 6'o22, 6'o77};
    logic [5:0] a2_tab [8] = '{6'o77, 6'o00, 6'o11, 6'o30, 6'o33, 6'o23, 6'o22, 6'o77};
    // en_e, en_2e, en_5e
    logic [2:0] en_tab [8] = '{3'b000, 3'b000, 3'b100, 3'b010, 3'b000, 3'b000, 3'b001, 3'b000};
    logic       vld_tab [8] = '{1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0};

    integer            seed = 32'h091fbf34;
    int                errors = 0;
    int                tests = 0;
    int                failed = 0;
    int                phase = 0;
    int                interp_mark = 0;
    // set when a wait runs out of cycles
    logic              stalled = 1'b0;
    // reference model of the burst counters
    logic [1:0]        m_cnt;
    logic              m_first;
    logic [1:0]        m_idx;
    logic [addr_w-1:0] m_rd;

    ch_est_ctrl_top #(
        .nrs_addr_w (addr_w)
    ) dut0 (
        .clk            (clk),
        .rst            (rst),
        .demap_ready    (demap_ready),
        .nrs_gen_ready  (nrs_gen_ready),
        .col            (col),
        .nrs_index_addr (nrs_index_addr),
        .rd_addr_nrs    (rd_addr_nrs),
        .demap_read     (demap_read),
        .est_ack_nrs    (est_ack_nrs),
        .est_ack_demap  (est_ack_demap),
        .addr_mem       (addr_mem),
        .mult_mem_en    (mult_mem_en),
        .avg_mem_en     (avg_mem_en),
        .valid_eqlz     (valid_eqlz),
        .sel_a1         (sel_a1),
        .sel_a2         (sel_a2),
        .reg_en         (reg_en),
        .s_h1           (s_h1),
        .s_h2           (s_h2)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // ========================================
    // helpers
    // ========================================

    task automatic expect_eq(input string name, input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp) begin
            $display("Error at %0t ns: %s expected %0h got %0h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic report_test(input string what, input int mark);
        tests++;
        if (errors == mark) begin
            $display("test %0d %s: ok", tests, what);
        end else begin
            failed++;
            $display("test %0d %s: FAILED", tests, what);
        end
    endtask

    // mux step p cycles after e3 where words load at p = 2
    function automatic logic [1:0] sel_step(input logic [11:0] word, input int p);
        logic [11:0] w;
        if (p < 2) begin
            return 2'b00;
        end
        w = word >> (2 * (p - 2));
        return w[1:0];
    endfunction

    // interpolation outputs checked every cycle
    task automatic check_interp;
        expect_eq("sel_a1", 32'(sel_a1), 32'(a1_tab[phase]));
        expect_eq("sel_a2", 32'(sel_a2), 32'(a2_tab[phase]));
        expect_eq("reg_en", 32'(reg_en), 32'(en_tab[phase]));
        expect_eq("valid_eqlz", 32'(valid_eqlz), 32'(vld_tab[phase]));
        expect_eq("s_h1", 32'(s_h1), 32'(sel_step(word_h1, phase)));
        expect_eq("s_h2", 32'(s_h2), 32'(sel_step(word_h2, phase)));
        if (phase == 7) begin
            report_test("interpolation", interp_mark);
            phase = 0;
        end else if (phase > 0) begin
            phase++;
        end
    endtask

    task automatic step;
        @(negedge clk);
        check_interp();
    endtask

    task automatic advance_model;
        if (m_cnt == 2'd3) begin
            m_first = ~m_first;
        end
        m_cnt = m_cnt + 2'd1;
        m_idx = m_idx + 2'd1;
        m_rd  = m_rd + addr_w'(2);
    endtask

    // extra cycles spent before the first active cycle
    task automatic wait_burst(output int waited);
        waited = 0;
        step();
        while (!demap_read && waited <= wait_limit) begin
            waited++;
            step();
        end
        if (!demap_read) begin
            $display("no burst started within %0d cycles of ready", wait_limit);
            stalled = 1'b1;
        end
    endtask

    // shared checks of both active cycles
    task automatic check_active(input logic [3:0] exp_col, input logic exp_e3);
        expect_eq("demap_read", 32'(demap_read), 32'd1);
        expect_eq("est_ack_nrs", 32'(est_ack_nrs), 32'd1);
        expect_eq("addr_mem", 32'(addr_mem), 32'(m_cnt));
        expect_eq("col", 32'(col), 32'(exp_col));
        expect_eq("nrs_index_addr", 32'(nrs_index_addr), 32'(m_idx));
        expect_eq("rd_addr_nrs", 32'(rd_addr_nrs), 32'(m_rd));
        expect_eq("est_ack_demap", 32'(est_ack_demap), 32'(exp_e3));
    endtask

    // ========================================
    // one burst per table row
    // ========================================

    task automatic run_burst(input int row);
        int   mark;
        int   n_idle;
        int   waited;
        logic add_k;
        logic e3_exp;
        mark = errors;
        add_k = kind_tab[row];
        n_idle = idle_tab[row];
        if (n_idle == 0) begin
            n_idle = 1 + ($unsigned($random(seed)) % 4);
        end
        repeat (n_idle) begin
            step();
            expect_eq("demap_read", 32'(demap_read), 32'd0);
        end
        demap_ready   = 1'b1;
        nrs_gen_ready = 1'b1;
        wait_burst(waited);
        demap_ready   = 1'b0;
        nrs_gen_ready = 1'b0;
        if (stalled) begin
            return;
        end
        // burst starts on the cycle right after ready
        if (waited != 0) begin
            $display("burst %0d started %0d cycles late", row, waited);
            errors++;
        end
        // first cycle has e3 on the second add burst only
        e3_exp = !m_first && (m_cnt == 2'd2);
        check_active(col_tab[row], e3_exp);
        expect_eq("mult_mem_en", 32'(mult_mem_en), 32'd0);
        expect_eq("avg_mem_en", 32'(avg_mem_en), 32'd0);
        if (e3_exp) begin
            phase = 1;
            interp_mark = errors;
        end
        advance_model();
        step();
        check_active(col_tab[row], 1'b0);
        expect_eq("mult_mem_en", 32'(mult_mem_en), 32'(!add_k));
        expect_eq("avg_mem_en", 32'(avg_mem_en), 32'(add_k));
        advance_model();
        // back in idle with the enable of the second cycle
        step();
        expect_eq("demap_read", 32'(demap_read), 32'd0);
        expect_eq("est_ack_nrs", 32'(est_ack_nrs), 32'd0);
        expect_eq("est_ack_demap", 32'(est_ack_demap), 32'd0);
        expect_eq("mult_mem_en", 32'(mult_mem_en), 32'(!add_k));
        expect_eq("avg_mem_en", 32'(avg_mem_en), 32'(add_k));
        expect_eq("nrs_index_addr", 32'(nrs_index_addr), 32'(m_idx));
        expect_eq("rd_addr_nrs", 32'(rd_addr_nrs), 32'(m_rd));
        report_test($sformatf("burst %0d %s col %0d", row, add_k ? "add" : "store",
                              col_tab[row]), mark);
    endtask

    // ========================================
    // main sequence
    // ========================================

    initial begin
        int mark;
        int n;
        demap_ready   = 1'b0;
        nrs_gen_ready = 1'b0;
        rst           = 1'b0;
        m_cnt         = 2'd0;
        m_first       = 1'b1;
        m_idx         = 2'd0;
        m_rd          = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        // state right after reset
        mark = errors;
        step();
        expect_eq("demap_read", 32'(demap_read), 32'd0);
        expect_eq("est_ack_nrs", 32'(est_ack_nrs), 32'd0);
        expect_eq("est_ack_demap", 32'(est_ack_demap), 32'd0);
        expect_eq("mult_mem_en", 32'(mult_mem_en), 32'd0);
        expect_eq("avg_mem_en", 32'(avg_mem_en), 32'd0);
        expect_eq("addr_mem", 32'(addr_mem), 32'd0);
        expect_eq("col", 32'(col), 32'd5);
        expect_eq("nrs_index_addr", 32'(nrs_index_addr), 32'd0);
        expect_eq("rd_addr_nrs", 32'(rd_addr_nrs), 32'd0);
        report_test("reset", mark);

        for (int r = 0; r < n_rows && !stalled; r++) begin
            run_burst(r);
        end

        // let the last interpolation run out
        n = 0;
        while (phase != 0 && !stalled && n <= wait_limit) begin
            n++;
            step();
        end
        if (phase != 0 && !stalled) begin
            $display("interpolation window did not finish");
            stalled = 1'b1;
        end

        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0 && !stalled) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
logic/ch_est_pkg.sv
logic/slot_mult_sched.sv
logic/pilot_addr_gen.sv
logic/interp_sched.sv
logic/out_sel_seq.sv
logic/ch_est_ctrl_top.sv
bench/ch_est_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
verilator --binary --timing --assert --top-module ch_est_ctrl_tb -f all.f -o ch_est_sim \
    && out=$(./obj_dir/ch_est_sim) \
    && printf '%s\n' "$out" \
    && printf '%s\n' "$out" | grep -qx "All checks passed" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
